// ==== Makefile ====
# Verilator build, run, lint and clean for the vector unit

VERILATOR  = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = vector_fixed_unit_tb
DUT_TOP    = vector_fixed_unit
FILELIST   = verilog.f
BUILD_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass is decided by the pass message in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== rtl/scalar_fixed_multiplier.sv ====
/* Sequential signed Q16.16 multiplier, one product in flight
   ready pulses exactly data_size + 2 cycles after start; start while busy is ignored
   Result is truncated toward zero and saturated */

`default_nettype none

module scalar_fixed_multiplier (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    start,
  input  vector_unit_pkg::fixed_t a,
  input  vector_unit_pkg::fixed_t b,
  output logic                    ready,
  output vector_unit_pkg::fixed_t product
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  vector_unit_pkg::mult_state_e state;
  vector_unit_pkg::mult_count_t count;

  // Shift-add datapath works on magnitudes
  logic [2*vector_unit_pkg::data_size-1:0] multiplicand;
  logic [vector_unit_pkg::data_size-1:0]   multiplier;
  logic [2*vector_unit_pkg::data_size-1:0] accumulator;
  logic                                    negative;

  logic [vector_unit_pkg::data_size-1:0]   mag_a;
  logic [vector_unit_pkg::data_size-1:0]   mag_b;
  logic [2*vector_unit_pkg::data_size-1:0] shifted;
  logic                                    over_pos;
  logic                                    over_neg;
  vector_unit_pkg::fixed_t                 product_next;

  //////////////////////////////////////////////////////////////////////
  // Magnitudes and final scaling
  //////////////////////////////////////////////////////////////////////

  // Most negative input gives 2^31, still fits unsigned
  assign mag_a = a[vector_unit_pkg::data_size-1] ? (~a + 1'b1) : a;
  assign mag_b = b[vector_unit_pkg::data_size-1] ? (~b + 1'b1) : b;

  // Dropping fraction bits of the magnitude truncates toward zero
  assign shifted = accumulator >> vector_unit_pkg::frac_bits;

  // Positive side tops out at 2^31 - 1
  assign over_pos = |shifted[2*vector_unit_pkg::data_size-1:vector_unit_pkg::data_size-1];
  // Negative side may reach 2^31 exactly
  assign over_neg = (|shifted[2*vector_unit_pkg::data_size-1:vector_unit_pkg::data_size])
                  || (shifted[vector_unit_pkg::data_size-1]
                      && |shifted[vector_unit_pkg::data_size-2:0]);

  always_comb begin
    if (negative) begin
      if (over_neg) begin
        product_next = vector_unit_pkg::fixed_min;
      end else begin
        product_next = ~shifted[vector_unit_pkg::data_size-1:0] + 1'b1;
      end
    end else if (over_pos) begin
      product_next = vector_unit_pkg::fixed_max;
    end else begin
      product_next = shifted[vector_unit_pkg::data_size-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= vector_unit_pkg::mult_idle;
      count        <= '0;
      multiplicand <= '0;
      multiplier   <= '0;
      accumulator  <= '0;
      negative     <= 1'b0;
      ready        <= 1'b0;
      product      <= '0;
    end else begin
      ready <= 1'b0;
      case (state)
        vector_unit_pkg::mult_idle: begin
          if (start) begin
            multiplicand <= {{vector_unit_pkg::data_size{1'b0}}, mag_a};
            multiplier   <= mag_b;
            accumulator  <= '0;
            negative     <= a[vector_unit_pkg::data_size-1] ^ b[vector_unit_pkg::data_size-1];
            count        <= '0;
            state        <= vector_unit_pkg::mult_busy;
          end
        end
        vector_unit_pkg::mult_busy: begin
          // One multiplier bit per cycle, LSB first
          if (multiplier[0]) begin
            accumulator <= accumulator + multiplicand;
          end
          multiplicand <= multiplicand << 1;
          multiplier   <= multiplier >> 1;
          count        <= count + 1'b1;
          if (count == vector_unit_pkg::mult_last) begin
            state <= vector_unit_pkg::mult_done;
          end
        end
        vector_unit_pkg::mult_done: begin
          // Sign and saturation applied here
          product <= product_next;
          ready   <= 1'b1;
          state   <= vector_unit_pkg::mult_idle;
        end
        default: begin
          state <= vector_unit_pkg::mult_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/vector_fixed_adder.sv ====
/* Element-wise saturated Q16.16 add or subtract, size 0 runs one element
   subtract is taken with start and holds for the whole vector */

`default_nettype none

module vector_fixed_adder (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      start,
  input  logic                      subtract,
  input  vector_unit_pkg::length_t  size,
  input  vector_unit_pkg::operand_t operand,
  output logic                      ready,
  output vector_unit_pkg::result_t  result
);

  vector_unit_pkg::vector_state_e         state;
  vector_unit_pkg::length_t               index;
  vector_unit_pkg::length_t               last_index;
  logic                                   subtract_q;

  vector_unit_pkg::fixed_t                a_value;
  vector_unit_pkg::fixed_t                b_value;
  logic                                   a_held;
  logic                                   b_held;

  // One guard bit catches overflow
  logic [vector_unit_pkg::data_size:0]    wide;
  vector_unit_pkg::fixed_t                sum_sat;

  //////////////////////////////////////////////////////////////////////
  // Saturated sum or difference
  //////////////////////////////////////////////////////////////////////

  assign wide = subtract_q
              ? ({a_value[vector_unit_pkg::data_size-1], a_value}
                 - {b_value[vector_unit_pkg::data_size-1], b_value})
              : ({a_value[vector_unit_pkg::data_size-1], a_value}
                 + {b_value[vector_unit_pkg::data_size-1], b_value});

  always_comb begin
    // Top two bits differ on overflow, guard bit gives the direction
    if (wide[vector_unit_pkg::data_size] != wide[vector_unit_pkg::data_size-1]) begin
      sum_sat = wide[vector_unit_pkg::data_size] ? vector_unit_pkg::fixed_min
                                                 : vector_unit_pkg::fixed_max;
    end else begin
      sum_sat = wide[vector_unit_pkg::data_size-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Capture and element loop
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= vector_unit_pkg::state_idle;
      index      <= '0;
      last_index <= '0;
      subtract_q <= 1'b0;
      a_value    <= '0;
      b_value    <= '0;
      a_held     <= 1'b0;
      b_held     <= 1'b0;
      ready      <= 1'b0;
      result     <= '0;
    end else begin
      ready         <= 1'b0;
      result.enable <= 1'b0;
      case (state)
        vector_unit_pkg::state_idle: begin
          index  <= '0;
          a_held <= 1'b0;
          b_held <= 1'b0;
          if (start) begin
            last_index <= (size == '0) ? '0 : size - 1'b1;
            subtract_q <= subtract;
            state      <= vector_unit_pkg::state_input;
          end
        end
        vector_unit_pkg::state_input: begin
          if (operand.a_enable) begin
            a_value <= operand.a;
          end
          if (operand.b_enable) begin
            b_value <= operand.b;
          end
          if (a_held && b_held) begin
            result.data   <= sum_sat;
            result.enable <= 1'b1;
            // Strobes in this cycle belong to the next element
            a_held        <= operand.a_enable;
            b_held        <= operand.b_enable;
            if (index == last_index) begin
              ready <= 1'b1;
              state <= vector_unit_pkg::state_idle;
            end else begin
              index <= index + 1'b1;
            end
          end else begin
            a_held <= a_held | operand.a_enable;
            b_held <= b_held | operand.b_enable;
          end
        end
        // No wait phase, result is one cycle behind the pair
        default: begin
          state <= vector_unit_pkg::state_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/vector_fixed_multiplier.sv ====
/* Element-wise Q16.16 multiply over a vector of size elements, size 0 runs one
   Operands for the next element may arrive while the current product is in flight
   No back-pressure; strobes in idle are dropped */

`default_nettype none

module vector_fixed_multiplier (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      start,
  input  vector_unit_pkg::length_t  size,
  input  vector_unit_pkg::operand_t operand,
  output logic                      ready,
  output vector_unit_pkg::result_t  result
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  vector_unit_pkg::vector_state_e state;
  vector_unit_pkg::length_t       index;
  vector_unit_pkg::length_t       last_index;

  // Captured operands and their presence flags
  vector_unit_pkg::fixed_t        a_value;
  vector_unit_pkg::fixed_t        b_value;
  logic                           a_held;
  logic                           b_held;
  logic                           launch;

  // Scalar multiplier side
  logic                           mult_start;
  logic                           mult_ready;
  vector_unit_pkg::fixed_t        mult_a;
  vector_unit_pkg::fixed_t        mult_b;
  vector_unit_pkg::fixed_t        mult_product;

  // Pair complete, hand it to the scalar unit
  assign launch = (state == vector_unit_pkg::state_input) && a_held && b_held;

  //////////////////////////////////////////////////////////////////////
  // Operand capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      a_value <= '0;
      b_value <= '0;
      a_held  <= 1'b0;
      b_held  <= 1'b0;
    end else if (state == vector_unit_pkg::state_idle) begin
      a_held <= 1'b0;
      b_held <= 1'b0;
    end else begin
      // Later strobe overwrites the value
      if (operand.a_enable) begin
        a_value <= operand.a;
      end
      if (operand.b_enable) begin
        b_value <= operand.b;
      end
      // On launch the flags restart for the next element
      if (launch) begin
        a_held <= operand.a_enable;
        b_held <= operand.b_enable;
      end else begin
        a_held <= a_held | operand.a_enable;
        b_held <= b_held | operand.b_enable;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Element loop
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= vector_unit_pkg::state_idle;
      index      <= '0;
      last_index <= '0;
      mult_start <= 1'b0;
      mult_a     <= '0;
      mult_b     <= '0;
      ready      <= 1'b0;
      result     <= '0;
    end else begin
      // Strobes are single-cycle
      mult_start    <= 1'b0;
      ready         <= 1'b0;
      result.enable <= 1'b0;
      case (state)
        vector_unit_pkg::state_idle: begin
          index <= '0;
          if (start) begin
            last_index <= (size == '0) ? '0 : size - 1'b1;
            state      <= vector_unit_pkg::state_input;
          end
        end
        vector_unit_pkg::state_input: begin
          // Pair copied out so capture can keep running
          if (launch) begin
            mult_a     <= a_value;
            mult_b     <= b_value;
            mult_start <= 1'b1;
            state      <= vector_unit_pkg::state_wait;
          end
        end
        vector_unit_pkg::state_wait: begin
          if (mult_ready) begin
            result.data   <= mult_product;
            result.enable <= 1'b1;
            if (index == last_index) begin
              ready <= 1'b1;
              state <= vector_unit_pkg::state_idle;
            end else begin
              index <= index + 1'b1;
              state <= vector_unit_pkg::state_input;
            end
          end
        end
        default: begin
          state <= vector_unit_pkg::state_idle;
        end
      endcase
    end
  end

  // Fixed latency scalar core
  scalar_fixed_multiplier u_scalar (
    .CLK    (CLK),
    .RST    (RST),
    .start  (mult_start),
    .a      (mult_a),
    .b      (mult_b),
    .ready  (mult_ready),
    .product(mult_product)
  );

endmodule

`default_nettype wire

// ==== rtl/vector_fixed_unit.sv ====
/* Top of the vector unit: multiply, add or subtract, one operation at a time
   start is honoured only while no operation runs, or in the cycle of ready */

`default_nettype none

module vector_fixed_unit (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  vector_unit_pkg::vector_op_e op,
  input  vector_unit_pkg::length_t    size,
  input  vector_unit_pkg::operand_t   operand,
  output logic                        ready,
  output vector_unit_pkg::result_t    result
);

  vector_unit_pkg::vector_op_e op_q;
  logic                        busy;
  logic                        accept;

  logic                        mul_start;
  logic                        mul_ready;
  vector_unit_pkg::result_t    mul_result;
  logic                        add_start;
  logic                        add_subtract;
  logic                        add_ready;
  vector_unit_pkg::result_t    add_result;

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////

  // Running operation ends with its ready
  assign accept       = start && (!busy || ready);
  assign mul_start    = accept && (op == vector_unit_pkg::op_mul);
  assign add_start    = accept && (op != vector_unit_pkg::op_mul);
  assign add_subtract = (op == vector_unit_pkg::op_sub);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      op_q <= vector_unit_pkg::op_mul;
      busy <= 1'b0;
    end else if (accept) begin
      op_q <= op;
      busy <= 1'b1;
    end else if (ready) begin
      busy <= 1'b0;
    end
  end

  // Output from the module that owns the running opcode
  always_comb begin
    if (op_q == vector_unit_pkg::op_mul) begin
      ready  = mul_ready;
      result = mul_result;
    end else begin
      ready  = add_ready;
      result = add_result;
    end
  end

  vector_fixed_multiplier u_mul (
    .CLK    (CLK),
    .RST    (RST),
    .start  (mul_start),
    .size   (size),
    .operand(operand),
    .ready  (mul_ready),
    .result (mul_result)
  );

  vector_fixed_adder u_add (
    .CLK     (CLK),
    .RST     (RST),
    .start   (add_start),
    .subtract(add_subtract),
    .size    (size),
    .operand (operand),
    .ready   (add_ready),
    .result  (add_result)
  );

endmodule

`default_nettype wire

// ==== rtl/vector_unit_pkg.sv ====
/* Shared widths, limits and types for the Q16.16 vector unit
   Values are signed two's complement with 16 fraction bits */

`default_nettype none

package vector_unit_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and number format
  //////////////////////////////////////////////////////////////////////

  localparam int data_size    = 32;
  localparam int frac_bits    = 16;
  localparam int control_size = 16;

  // Signed Q16.16 value and vector length
  typedef logic signed [data_size-1:0] fixed_t;
  typedef logic [control_size-1:0]     length_t;

  // Saturation limits
  localparam fixed_t fixed_max = 32'sh7fff_ffff;
  localparam fixed_t fixed_min = 32'sh8000_0000;

  // Step counter of the shift-add multiplier, one step per operand bit
  typedef logic [$clog2(data_size)-1:0] mult_count_t;
  localparam mult_count_t mult_last = mult_count_t'(data_size - 1);

  //////////////////////////////////////////////////////////////////////
  // Opcodes and FSM states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {op_mul, op_add, op_sub} vector_op_e;

  typedef enum logic [1:0] {state_idle, state_input, state_wait} vector_state_e;

  typedef enum logic [1:0] {mult_idle, mult_busy, mult_done} mult_state_e;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////

  // Each side strobed on its own
  typedef struct packed {
    logic   a_enable;
    fixed_t a;
    logic   b_enable;
    fixed_t b;
  } operand_t;

  typedef struct packed {
    logic   enable;
    fixed_t data;
  } result_t;

endpackage

`default_nettype wire

// ==== verif/vector_fixed_unit_tb.sv ====
/* Directed testbench for the Q16.16 vector unit with one element in flight per drive
   Expected values come from a local model with truncation toward zero and saturation */

`default_nettype none

module vector_fixed_unit_tb;

  //////////////////////////////////////////////////////////////////////
  // Constants and signals
  //////////////////////////////////////////////////////////////////////

  localparam int     clock_period    = 4;
  localparam int     total_elements  = 45;
  // Split multiply is the slowest element at about 42 cycles
  localparam int     watchdog_cycles = total_elements * (32 + 10) + 1000;
  localparam longint q_max           = 64'sh0000_0000_7fff_ffff;
  localparam longint q_min           = 64'shffff_ffff_8000_0000;

  logic                        CLK;
  logic                        RST;
  logic                        start;
  vector_unit_pkg::vector_op_e op;
  vector_unit_pkg::length_t    size;
  vector_unit_pkg::operand_t   operand;
  logic                        ready;
  vector_unit_pkg::result_t    result;

  integer      seed;
  logic [31:0] a_list[$];
  logic [31:0] b_list[$];
  logic [31:0] exp_q[$];
  int          seen_count;
  int          pending_ready;

  vector_fixed_unit dut (
    .CLK    (CLK),
    .RST    (RST),
    .start  (start),
    .op     (op),
    .size   (size),
    .operand(operand),
    .ready  (ready),
    .result (result)
  );

  always #(clock_period / 2) CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] expected_value(input vector_unit_pkg::vector_op_e kind,
                                                 input logic signed [31:0] a,
                                                 input logic signed [31:0] b);
    longint scaled;
    case (kind)
      // Signed division truncates toward zero
      vector_unit_pkg::op_mul: scaled = (longint'(a) * longint'(b)) / 64'sd65536;
      vector_unit_pkg::op_add: scaled = longint'(a) + longint'(b);
      default:                 scaled = longint'(a) - longint'(b);
    endcase
    if (scaled > q_max) begin
      scaled = q_max;
    end else if (scaled < q_min) begin
      scaled = q_min;
    end
    return scaled[31:0];
  endfunction

  // Arithmetic shift keeps the sign
  // Smaller shift gives a wider range
  function automatic logic [31:0] random_fixed(input int shift);
    logic [31:0] r;
    r = $random(seed);
    return $signed(r) >>> shift;
  endfunction

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      stop_run($sformatf("[ERROR] t=%0t %s: actual %h expected %h",
                         $time, name, actual, expected));
    end
  endtask

  task automatic push_pair(input logic [31:0] a, input logic [31:0] b);
    a_list.push_back(a);
    b_list.push_back(b);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Result collector sampled away from the driving edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST) begin
      if (result.enable) begin
        if (exp_q.size() == 0) begin
          stop_run($sformatf("[ERROR] t=%0t result pulse with no result expected", $time));
        end
        check("result.data", result.data, exp_q.pop_front());
        seen_count++;
      end
      // Ready only with or after the last result of the running vector
      if (ready) begin
        if (pending_ready == 0) begin
          stop_run($sformatf("[ERROR] t=%0t ready pulse with no operation ending", $time));
        end else if (exp_q.size() != 0) begin
          stop_run($sformatf("[ERROR] t=%0t ready pulse before the last result", $time));
        end
        pending_ready = 0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Drivers entered and left on a rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic drive_same(input logic [31:0] a, input logic [31:0] b);
    operand.a        <= a;
    operand.b        <= b;
    operand.a_enable <= 1'b1;
    operand.b_enable <= 1'b1;
    @(posedge CLK);
    operand.a_enable <= 1'b0;
    operand.b_enable <= 1'b0;
  endtask

  // B strobe and two idle cycles before the A strobe
  task automatic drive_split(input logic [31:0] a, input logic [31:0] b);
    operand.b        <= b;
    operand.b_enable <= 1'b1;
    @(posedge CLK);
    operand.b_enable <= 1'b0;
    @(posedge CLK);
    @(posedge CLK);
    operand.a        <= a;
    operand.a_enable <= 1'b1;
    @(posedge CLK);
    operand.a_enable <= 1'b0;
  endtask

  task automatic run_vector(input vector_unit_pkg::vector_op_e kind, input bit split);
    int n;
    int base;
    int waited;
    n    = a_list.size();
    base = seen_count;
    for (int i = 0; i < n; i++) begin
      exp_q.push_back(expected_value(kind, a_list[i], b_list[i]));
    end
    pending_ready = 1;
    start <= 1'b1;
    op    <= kind;
    size  <= 16'(n);
    @(posedge CLK);
    start <= 1'b0;
    // Next pair only after the current result
    for (int i = 0; i < n; i++) begin
      if (split) begin
        drive_split(a_list[i], b_list[i]);
      end else begin
        drive_same(a_list[i], b_list[i]);
      end
      while (seen_count < base + i + 1) begin
        @(posedge CLK);
      end
    end
    waited = 0;
    while (pending_ready != 0 && waited < 4) begin
      @(posedge CLK);
      waited++;
    end
    if (pending_ready != 0) begin
      stop_run($sformatf("[ERROR] t=%0t no ready pulse after the last result", $time));
    end
    a_list.delete();
    b_list.delete();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_quiet_test();
    repeat (10) begin
      @(negedge CLK);
      check("ready", 32'(ready), 32'd0);
      check("result.enable", 32'(result.enable), 32'd0);
    end
    @(posedge CLK);
  endtask

  task automatic mul_same_cycle_test();
    repeat (8) begin
      push_pair(random_fixed(10), random_fixed(10));
    end
    run_vector(vector_unit_pkg::op_mul, 1'b0);
  endtask

  task automatic mul_split_saturation_test();
    push_pair(32'h0003_8000, 32'hfffd_c000);
    push_pair(32'hfffe_8000, 32'hfffe_8000);
    push_pair(32'h8000_0000, 32'h8000_0000);
    push_pair(32'h7fff_ffff, 32'h0002_0000);
    push_pair(32'h8000_0000, 32'h0002_0000);
    // Tiny negative product goes to zero and not to -1 LSB
    push_pair(32'hffff_ffff, 32'h0000_0001);
    push_pair(32'hffff_0001, 32'h0000_8000);
    // Exactly the most negative value
    push_pair(32'h0080_0000, 32'hff00_0000);
    run_vector(vector_unit_pkg::op_mul, 1'b1);
  endtask

  task automatic add_sub_test();
    for (int i = 0; i < 8; i++) begin
      push_pair(random_fixed((i % 2) * 4), random_fixed((i % 2) * 4));
    end
    push_pair(32'h7fff_ffff, 32'h0000_0001);
    push_pair(32'h8000_0000, 32'hffff_ffff);
    run_vector(vector_unit_pkg::op_add, 1'b0);
    for (int i = 0; i < 8; i++) begin
      push_pair(random_fixed((i % 2) * 4), random_fixed((i % 2) * 4));
    end
    push_pair(32'h8000_0000, 32'h0000_0001);
    push_pair(32'h7fff_ffff, 32'hffff_ffff);
    run_vector(vector_unit_pkg::op_sub, 1'b1);
  endtask

  // Each operation starts on the edge after the previous ready
  task automatic back_to_back_test();
    repeat (5) begin
      push_pair(random_fixed(10), random_fixed(10));
    end
    run_vector(vector_unit_pkg::op_mul, 1'b0);
    push_pair(random_fixed(2), random_fixed(2));
    run_vector(vector_unit_pkg::op_add, 1'b1);
    repeat (3) begin
      push_pair(random_fixed(1), random_fixed(1));
    end
    run_vector(vector_unit_pkg::op_sub, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    CLK           = 1'b0;
    RST           = 1'b1;
    start         = 1'b0;
    op            = vector_unit_pkg::op_mul;
    size          = '0;
    operand       = '0;
    seed          = 32'h9c7feb56;
    seen_count    = 0;
    pending_ready = 0;
    repeat (8) @(posedge CLK);
    RST <= 1'b0;
    reset_quiet_test();
    mul_same_cycle_test();
    mul_split_saturation_test();
    add_sub_test();
    back_to_back_test();
    // Room for a stray pulse to show up
    repeat (6) @(posedge CLK);
    $display("TESTS PASSED");
    $finish;
  end

  initial begin
    #(watchdog_cycles * clock_period);
    stop_run($sformatf("[ERROR] t=%0t timeout, the tests did not finish in time", $time));
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/vector_unit_pkg.sv
rtl/scalar_fixed_multiplier.sv
rtl/vector_fixed_multiplier.sv
rtl/vector_fixed_adder.sv
rtl/vector_fixed_unit.sv
verif/vector_fixed_unit_tb.sv
